/* logic/retire_defines.svh */
// Sizes shared by the retire logic and its testbench
// ROB_DEPTH should be a power of two; DATA_WIDTH is assumed to be 32

`ifndef RETIRE_DEFINES_SVH
`define RETIRE_DEFINES_SVH

// ROB slots
`define ROB_DEPTH 8

// Physical registers, register 0 means no destination
`define PHY_RF_REGS 64

// Data, address and PC width
`define DATA_WIDTH 32

// Free slots still open when rob_full rises
`define ROB_FULL_SLACK 2

`endif

/* logic/retire_pkg.sv */
// Types shared between the ROB, the retire decision and the busy table
// Size codes follow the RISC-V funct3 encoding for loads and stores

`include "retire_defines.svh"

package retire_pkg;

    localparam int PHY_RF_ADDR_W = $clog2(`PHY_RF_REGS);

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_addr_t;
    typedef logic [PHY_RF_ADDR_W-1:0]      phy_rf_addr_t;
    typedef logic [`DATA_WIDTH-1:0]        phy_rf_data_t;
    typedef logic [`DATA_WIDTH-1:0]        pc_t;

    typedef enum logic [2:0] {
        OPTYPE_NONE,
        OPTYPE_ALU,
        OPTYPE_BRANCH,
        OPTYPE_JUMP,
        OPTYPE_LOAD,
        OPTYPE_STORE
    } optype_t;

    typedef enum logic [2:0] {
        FUNCT3_B  = 3'b000,
        FUNCT3_H  = 3'b001,
        FUNCT3_W  = 3'b010,
        FUNCT3_BU = 3'b100,
        FUNCT3_HU = 3'b101
    } ldst_funct3_t;

    typedef enum logic {
        ROB_EMPTY,
        ROB_COMPLETE
    } rob_state_t;

    // Store address for stores, register destination for everything else
    typedef union packed {
        logic [`DATA_WIDTH-1:0] dmem_dest;
        struct packed {
            logic [`DATA_WIDTH-PHY_RF_ADDR_W-1:0] pad;
            phy_rf_addr_t                         phy_dest;
        } phy;
    } rob_dest_u;

    typedef struct packed {
        logic         valid;
        rob_addr_t    rob_addr;
        optype_t      optype;
        ldst_funct3_t funct3;
        phy_rf_addr_t phy_dest;
        phy_rf_addr_t phyreg_old;
        pc_t          pc;
        phy_rf_data_t value;
        phy_rf_data_t store_data;
        logic         taken;
    } complete_t;

    typedef struct packed {
        rob_state_t   state;
        optype_t      optype;
        ldst_funct3_t funct3;
        rob_dest_u    dest;
        phy_rf_addr_t phyreg_old;
        phy_rf_data_t value;
        pc_t          pc_new;
        logic         mispredicted;
    } rob_entry_t;

    typedef struct packed {
        logic         en;
        phy_rf_addr_t addr;
        phy_rf_data_t data;
    } rf_write_t;

    typedef struct packed {
        logic [3:0]             wr_mask;
        logic                   rd_en;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } dmem_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } dmem_resp_t;

    typedef struct packed {
        logic         en;
        rob_addr_t    rob_addr;
        phy_rf_data_t value;
        phy_rf_addr_t freed_reg;
    } retire_info_t;

endpackage

/* logic/rob_ram.sv */
// ROB slot storage, asynchronous head read
// Only the slot state is reset; payload is valid while the state is complete

`timescale 1ns/1ps

`include "retire_defines.svh"

module rob_ram import retire_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr1_en,
    input  rob_addr_t  wr1_addr,
    input  rob_entry_t wr1_in,
    input  logic       wr2_en,
    input  rob_addr_t  wr2_addr,
    input  rob_addr_t  rd_addr,
    output rob_entry_t rd_out
);

    rob_state_t state_q [`ROB_DEPTH];
    rob_entry_t slots   [`ROB_DEPTH];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `ROB_DEPTH; i++)
                state_q[i] <= ROB_EMPTY;
        end
        else
        begin
            if (wr2_en)
                state_q[wr2_addr] <= ROB_EMPTY;
            // Completion wins on a shared slot
            if (wr1_en)
                state_q[wr1_addr] <= wr1_in.state;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr1_en)
            slots[wr1_addr] <= wr1_in;
    end

    always_comb
    begin
        rd_out       = slots[rd_addr];
        rd_out.state = state_q[rd_addr];
    end

    // Each allocated slot completes once before it retires
    a_no_double_complete: assert property (@(posedge clk) disable iff (rst)
        wr1_en |-> state_q[wr1_addr] == ROB_EMPTY);

endmodule

/* logic/retire_stage.sv */
// ROB pointers, entry builder and in-order retirement at the head
// Sub-word loads and stores use the low byte lanes; the address is not shifted
// All branches are taken as predicted not taken

`timescale 1ns/1ps

`include "retire_defines.svh"

module retire_stage import retire_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         rob_alloc,
    input  complete_t    complete,
    input  dmem_resp_t   dmem_resp,
    output rob_addr_t    rob_tail,
    output logic         rob_full,
    output rf_write_t    rf_write,
    output dmem_req_t    dmem_req,
    output retire_info_t retire_info,
    output logic         mispredict,
    output pc_t          redirect_pc
);

    rob_addr_t                    head_q;
    rob_addr_t                    tail_q;
    logic [$clog2(`ROB_DEPTH):0]  count_q;

    rob_entry_t   wr1_in;
    rob_entry_t   head;
    logic         head_ready;
    logic         is_load;
    logic         is_store;
    logic         load_hit;
    logic         retire_en;
    phy_rf_data_t load_data;

    function automatic rob_addr_t next_ptr(input rob_addr_t ptr);
        next_ptr = (ptr == rob_addr_t'(`ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (rob_alloc)
                tail_q <= next_ptr(tail_q);
            if (retire_en)
                head_q <= next_ptr(head_q);
            case ({rob_alloc, retire_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign rob_tail = tail_q;
    assign rob_full = (`ROB_DEPTH - int'(count_q)) <= `ROB_FULL_SLACK;

    // Entry builder
    always_comb
    begin
        wr1_in.state      = ROB_COMPLETE;
        wr1_in.optype     = complete.optype;
        wr1_in.funct3     = complete.funct3;
        wr1_in.phyreg_old = complete.phyreg_old;
        wr1_in.pc_new     = complete.value;
        wr1_in.mispredicted = (complete.optype == OPTYPE_JUMP) ||
                              (complete.optype == OPTYPE_BRANCH && complete.taken);

        if (complete.optype == OPTYPE_STORE)
        begin
            wr1_in.dest.dmem_dest = complete.value;
            wr1_in.value          = complete.store_data;
        end
        else
        begin
            wr1_in.dest.phy.pad      = '0;
            wr1_in.dest.phy.phy_dest = complete.phy_dest;
            // Jump links pc + 4, loads keep their address here
            wr1_in.value = (complete.optype == OPTYPE_JUMP) ? complete.pc + 'd4
                                                            : complete.value;
        end
    end

    rob_ram u_ram (
        .clk      (clk),
        .rst      (rst),
        .wr1_en   (complete.valid),
        .wr1_addr (complete.rob_addr),
        .wr1_in   (wr1_in),
        .wr2_en   (retire_en),
        .wr2_addr (head_q),
        .rd_addr  (head_q),
        .rd_out   (head)
    );

    assign head_ready = head.state == ROB_COMPLETE;
    assign is_load    = head.optype == OPTYPE_LOAD;
    assign is_store   = head.optype == OPTYPE_STORE;
    assign load_hit   = dmem_resp.valid && dmem_resp.addr == head.value;
    assign retire_en  = head_ready && (!is_load || load_hit);

    always_comb
    begin
        case (head.funct3)
            FUNCT3_B:  load_data = {{24{dmem_resp.data[7]}}, dmem_resp.data[7:0]};
            FUNCT3_H:  load_data = {{16{dmem_resp.data[15]}}, dmem_resp.data[15:0]};
            FUNCT3_BU: load_data = {24'b0, dmem_resp.data[7:0]};
            FUNCT3_HU: load_data = {16'b0, dmem_resp.data[15:0]};
            default:   load_data = dmem_resp.data;
        endcase
    end

    // Head decision
    always_comb
    begin
        rf_write.en   = retire_en && !is_store && head.dest.phy.phy_dest != '0;
        rf_write.addr = head.dest.phy.phy_dest;
        rf_write.data = is_load ? load_data : head.value;

        // Read stays up through the response cycle
        dmem_req.rd_en = head_ready && is_load;
        dmem_req.addr  = is_store ? head.dest.dmem_dest : head.value;
        dmem_req.data  = head.value;
        dmem_req.wr_mask = 4'b0000;
        if (head_ready && is_store)
        begin
            case (head.funct3)
                FUNCT3_B: dmem_req.wr_mask = 4'b0001;
                FUNCT3_H: dmem_req.wr_mask = 4'b0011;
                FUNCT3_W: dmem_req.wr_mask = 4'b1111;
                default:  dmem_req.wr_mask = 4'b0000;
            endcase
        end

        mispredict  = retire_en && head.mispredicted;
        redirect_pc = head.pc_new;

        retire_info.en        = retire_en;
        retire_info.rob_addr  = head_q;
        retire_info.value     = rf_write.data;
        retire_info.freed_reg = head.phyreg_old;
    end

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        rob_alloc |-> !rob_full);

    a_no_retire_when_empty: assert property (@(posedge clk) disable iff (rst)
        retire_en |-> count_q != '0);

endmodule

/* logic/busy_table.sv */
// One busy bit per physical register
// Set from rename wins over a retirement clear in the same cycle

`timescale 1ns/1ps

`include "retire_defines.svh"

module busy_table import retire_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      set_en,
    input  phy_rf_addr_t              set_addr,
    input  rf_write_t                 clr,
    output logic [`PHY_RF_REGS-1:0]   busy
);

    logic [`PHY_RF_REGS-1:0] busy_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= '0;
        end
        else
        begin
            if (clr.en)
                busy_q[clr.addr] <= 1'b0;
            // Register 0 has no value to wait for
            if (set_en && set_addr != '0)
                busy_q[set_addr] <= 1'b1;
        end
    end

    assign busy = busy_q;

endmodule

/* logic/retire_top.sv */
// Retire end of the core: ROB with retirement, plus the busy table
// rob_alloc must stay low while rob_full is high

`timescale 1ns/1ps

`include "retire_defines.svh"

module retire_top import retire_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rob_alloc,
    input  complete_t                 complete,
    input  logic                      busy_set,
    input  phy_rf_addr_t              busy_set_addr,
    input  dmem_resp_t                dmem_resp,
    output rf_write_t                 rf_write,
    output dmem_req_t                 dmem_req,
    output retire_info_t              retire_info,
    output logic                      mispredict,
    output pc_t                       redirect_pc,
    output rob_addr_t                 rob_tail,
    output logic                      rob_full,
    output logic [`PHY_RF_REGS-1:0]   busy
);

    retire_stage u_retire (
        .clk         (clk),
        .rst         (rst),
        .rob_alloc   (rob_alloc),
        .complete    (complete),
        .dmem_resp   (dmem_resp),
        .rob_tail    (rob_tail),
        .rob_full    (rob_full),
        .rf_write    (rf_write),
        .dmem_req    (dmem_req),
        .retire_info (retire_info),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    // Register writes at retirement clear the busy bits
    busy_table u_busy (
        .clk      (clk),
        .rst      (rst),
        .set_en   (busy_set),
        .set_addr (busy_set_addr),
        .clr      (rf_write),
        .busy     (busy)
    );

endmodule

/* bench/retire_tb.sv */
// Seeded random ops for retire_top checked against a queue of expected retirements
// Memory serves one read at a time from word addresses below 1 KiB

`timescale 1ns/1ps

`include "retire_defines.svh"

module retire_tb import retire_pkg::*; ();

    localparam int BATCH   = `ROB_DEPTH - `ROB_FULL_SLACK;
    localparam int TIMEOUT = 200;

    logic                    clk;
    logic                    rst;
    logic                    rob_alloc;
    complete_t               complete;
    logic                    busy_set;
    phy_rf_addr_t            busy_set_addr;
    dmem_resp_t              dmem_resp;
    rf_write_t               rf_write;
    dmem_req_t               dmem_req;
    retire_info_t            retire_info;
    logic                    mispredict;
    pc_t                     redirect_pc;
    rob_addr_t               rob_tail;
    logic                    rob_full;
    logic [`PHY_RF_REGS-1:0] busy;

    integer      seed;
    int          errors;
    int          passed;
    int          failed;
    logic        hung;
    rob_addr_t   tail_m;
    complete_t   exp_q [$];
    logic [31:0] mem [256];
    logic        rd_wait;
    int          rd_delay;

    retire_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .rob_alloc     (rob_alloc),
        .complete      (complete),
        .busy_set      (busy_set),
        .busy_set_addr (busy_set_addr),
        .dmem_resp     (dmem_resp),
        .rf_write      (rf_write),
        .dmem_req      (dmem_req),
        .retire_info   (retire_info),
        .mispredict    (mispredict),
        .redirect_pc   (redirect_pc),
        .rob_tail      (rob_tail),
        .rob_full      (rob_full),
        .busy          (busy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic report(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_rf(input rf_write_t got, input rf_write_t exp);
        if (got.en !== exp.en || (exp.en && (got.addr !== exp.addr || got.data !== exp.data)))
            report($sformatf("rf_write en=%b addr=%0d data=%h, expected en=%b addr=%0d data=%h",
                got.en, got.addr, got.data, exp.en, exp.addr, exp.data));
    endtask

    task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
        logic bad;
        bad = got.rd_en !== exp.rd_en || got.wr_mask !== exp.wr_mask;
        if ((exp.rd_en || exp.wr_mask != 4'b0) && got.addr !== exp.addr)
            bad = 1'b1;
        if (exp.wr_mask != 4'b0 && got.data !== exp.data)
            bad = 1'b1;
        if (bad)
            report($sformatf("dmem_req rd=%b mask=%b addr=%h data=%h, expected %b %b %h %h",
                got.rd_en, got.wr_mask, got.addr, got.data,
                exp.rd_en, exp.wr_mask, exp.addr, exp.data));
    endtask

    task automatic check_redirect(input pc_t got, input pc_t exp);
        if (got !== exp)
            report($sformatf("redirect_pc %h, expected %h", got, exp));
    endtask

    task automatic check_retire(input retire_info_t got, input retire_info_t exp);
        if (got !== exp)
            report($sformatf("retire slot=%0d value=%h freed=%0d, expected %0d %h %0d",
                got.rob_addr, got.value, got.freed_reg,
                exp.rob_addr, exp.value, exp.freed_reg));
    endtask

    // RISC-V load extension from the low lanes
    function automatic phy_rf_data_t extend(input phy_rf_data_t w, input ldst_funct3_t f3);
        case (f3)
            FUNCT3_B:  extend = {{24{w[7]}}, w[7:0]};
            FUNCT3_H:  extend = {{16{w[15]}}, w[15:0]};
            FUNCT3_BU: extend = {24'b0, w[7:0]};
            FUNCT3_HU: extend = {16'b0, w[15:0]};
            default:   extend = w;
        endcase
    endfunction

    function automatic logic [3:0] size_mask(input ldst_funct3_t f3);
        case (f3)
            FUNCT3_B: size_mask = 4'b0001;
            FUNCT3_H: size_mask = 4'b0011;
            default:  size_mask = 4'b1111;
        endcase
    endfunction

    // kind 0 alu, 1 load, 2 store, 3 branch or jump
    function automatic complete_t make_op(input int kind, input rob_addr_t slot);
        complete_t op;
        int        pick;
        op            = '0;
        op.valid      = 1'b1;
        op.rob_addr   = slot;
        op.optype     = OPTYPE_ALU;
        op.funct3     = FUNCT3_W;
        op.phy_dest   = phy_rf_addr_t'($random(seed));
        op.phyreg_old = phy_rf_addr_t'($random(seed));
        op.pc         = $random(seed) & 32'hffff_fffc;
        op.value      = $random(seed);
        op.store_data = $random(seed);
        pick          = {$random(seed)} % 5;
        case (kind)
            1:
            begin
                op.optype = OPTYPE_LOAD;
                op.value  = {22'b0, 8'($random(seed)), 2'b00};
                case (pick)
                    0:       op.funct3 = FUNCT3_B;
                    1:       op.funct3 = FUNCT3_H;
                    2:       op.funct3 = FUNCT3_BU;
                    3:       op.funct3 = FUNCT3_HU;
                    default: op.funct3 = FUNCT3_W;
                endcase
            end
            2:
            begin
                op.optype = OPTYPE_STORE;
                op.funct3 = (pick < 2) ? FUNCT3_B : (pick < 4) ? FUNCT3_H : FUNCT3_W;
            end
            3:
            begin
                op.optype = (pick < 2) ? OPTYPE_JUMP : OPTYPE_BRANCH;
                op.taken  = pick[0];
                if (op.optype == OPTYPE_BRANCH)
                    op.phy_dest = '0;
            end
            default:
            begin
                if (pick == 0)
                    op.phy_dest = '0;
            end
        endcase
        return op;
    endfunction

    // Memory responder answering the head read after 0 to 5 cycles
    always @(negedge clk)
    begin
        dmem_resp.valid = 1'b0;
        if (rst)
        begin
            rd_wait = 1'b0;
        end
        else
        begin
            if (dmem_req.rd_en && !rd_wait)
            begin
                rd_wait  = 1'b1;
                rd_delay = {$random(seed)} % 6;
            end
            if (rd_wait && rd_delay == 0)
            begin
                dmem_resp.valid = 1'b1;
                dmem_resp.addr  = dmem_req.addr;
                dmem_resp.data  = mem[dmem_req.addr[9:2]];
                rd_wait         = 1'b0;
            end
            else if (rd_wait)
            begin
                rd_delay--;
            end
        end
    end

    task automatic check_cycle();
        complete_t    op;
        rf_write_t    exp_rf;
        dmem_req_t    exp_mem;
        retire_info_t exp_ri;
        logic         exp_mis;
        exp_mem = '0;
        if (!retire_info.en)
        begin
            check_flag(rf_write.en, 1'b0, "rf_write.en without retirement");
            check_flag(mispredict, 1'b0, "mispredict without retirement");
            // A read in flight keeps rd_en up at the head load address
            if (rd_wait && exp_q.size() > 0 && exp_q[0].optype == OPTYPE_LOAD)
            begin
                exp_mem.rd_en = 1'b1;
                exp_mem.addr  = exp_q[0].value;
            end
            check_store(dmem_req, exp_mem);
            return;
        end
        if (exp_q.size() == 0)
        begin
            $display("Error at %0t: an entry retired but none was in flight", $time);
            errors++;
            return;
        end
        op = exp_q.pop_front();
        exp_ri.en        = 1'b1;
        exp_ri.rob_addr  = op.rob_addr;
        exp_ri.freed_reg = op.phyreg_old;
        case (op.optype)
            OPTYPE_LOAD:  exp_ri.value = extend(mem[op.value[9:2]], op.funct3);
            OPTYPE_JUMP:  exp_ri.value = op.pc + 32'd4;
            OPTYPE_STORE: exp_ri.value = op.store_data;
            default:      exp_ri.value = op.value;
        endcase
        exp_rf.en     = op.optype != OPTYPE_STORE && op.phy_dest != '0;
        exp_rf.addr   = op.phy_dest;
        exp_rf.data   = exp_ri.value;
        exp_mem.rd_en = op.optype == OPTYPE_LOAD;
        exp_mem.addr  = op.value;
        if (op.optype == OPTYPE_STORE)
        begin
            exp_mem.wr_mask = size_mask(op.funct3);
            exp_mem.data    = op.store_data;
        end
        exp_mis = op.optype == OPTYPE_JUMP || (op.optype == OPTYPE_BRANCH && op.taken);
        check_retire(retire_info, exp_ri);
        check_rf(rf_write, exp_rf);
        check_store(dmem_req, exp_mem);
        check_flag(mispredict, exp_mis, "mispredict");
        if (exp_mis)
            check_redirect(redirect_pc, op.value);
    endtask

    // Outputs settle well before the next rising edge
    always @(negedge clk)
    begin
        #10;
        if (!rst)
            check_cycle();
    end

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timeout: %0d ROB entries never retired", exp_q.size());
            hung = 1'b1;
            exp_q.delete();
        end
    endtask

    // Fill to the full limit, then complete in shuffled order
    task automatic run_batch(input int kind);
        complete_t ops [BATCH];
        int        order [BATCH];
        int        j;
        int        tmp;
        for (int i = 0; i < BATCH; i++)
        begin
            @(negedge clk);
            check_flag(rob_full, (`ROB_DEPTH - i) <= `ROB_FULL_SLACK, "rob_full");
            if (rob_tail !== tail_m)
                report($sformatf("rob_tail %0d, expected %0d", rob_tail, tail_m));
            ops[i] = make_op(kind, tail_m);
            exp_q.push_back(ops[i]);
            order[i] = i;
            rob_alloc = 1'b1;
            tail_m++;
        end
        @(negedge clk);
        rob_alloc = 1'b0;
        check_flag(rob_full, 1'b1, "rob_full at the allocation limit");
        for (int i = BATCH - 1; i > 0; i--)
        begin
            j        = {$random(seed)} % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < BATCH; i++)
        begin
            complete = ops[order[i]];
            @(negedge clk);
        end
        complete.valid = 1'b0;
        wait_drain();
    endtask

    task automatic test_busy();
        complete_t    op;
        phy_rf_addr_t reg_a;
        reg_a = phy_rf_addr_t'(1 + {$random(seed)} % (`PHY_RF_REGS - 1));
        @(negedge clk);
        busy_set      = 1'b1;
        busy_set_addr = reg_a;
        @(negedge clk);
        busy_set = 1'b0;
        check_flag(busy[reg_a], 1'b1, "busy bit after rename set");
        for (int pass = 0; pass < 2; pass++)
        begin
            op          = make_op(0, tail_m);
            op.phy_dest = reg_a;
            exp_q.push_back(op);
            rob_alloc = 1'b1;
            tail_m++;
            @(negedge clk);
            rob_alloc = 1'b0;
            complete  = op;
            @(negedge clk);
            complete.valid = 1'b0;
            // Second pass sets the register again in its retire cycle
            busy_set = pass == 1;
            @(negedge clk);
            busy_set = 1'b0;
            wait_drain();
            check_flag(busy[reg_a], pass == 1, "busy bit after retirement");
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before && !hung)
        begin
            passed++;
            $display("[PASS] %s", name);
        end
        else
        begin
            failed++;
            $display("[FAIL] %s, %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic run_tests();
        int e;
        e = errors;
        check_flag(rob_full, 1'b0, "rob_full after reset");
        check_flag(rob_tail == '0, 1'b1, "rob_tail zero after reset");
        check_flag(busy == '0, 1'b1, "busy clear after reset");
        check_flag(rf_write.en || dmem_req.rd_en || dmem_req.wr_mask != 4'b0, 1'b0,
            "memory or register enable after reset");
        check_flag(mispredict || retire_info.en, 1'b0, "retire outputs after reset");
        run_batch(0);
        end_test("reset state and rob_full", e);
        for (int t = 0; t < 4 && !hung; t++)
        begin
            e = errors;
            for (int b = 0; b < 4 && !hung; b++)
                run_batch(t);
            case (t)
                0:       end_test("ALU retire order", e);
                1:       end_test("loads", e);
                2:       end_test("stores", e);
                default: end_test("branches and jumps", e);
            endcase
        end
        if (hung)
            return;
        e = errors;
        test_busy();
        end_test("busy table", e);
    endtask

    initial
    begin
        seed          = 12162;
        rst           = 1'b1;
        rob_alloc     = 1'b0;
        complete      = '0;
        busy_set      = 1'b0;
        busy_set_addr = '0;
        dmem_resp     = '0;
        errors        = 0;
        passed        = 0;
        failed        = 0;
        hung          = 1'b0;
        tail_m        = '0;
        rd_wait       = 1'b0;
        rd_delay      = 0;
        for (int i = 0; i < 256; i++)
            mem[i] = $random(seed);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_tests();
        $display("Summary: %0d tests passed, %0d failed, %0d check errors",
            passed, failed, errors);
        if (errors == 0 && failed == 0 && !hung)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/retire_pkg.sv
logic/rob_ram.sv
logic/retire_stage.sv
logic/busy_table.sv
logic/retire_top.sv
bench/retire_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module retire_tb -f project.f -o retire_sim > "$LOG" 2>&1 &&
    ./obj_dir/retire_sim >> "$LOG" 2>&1 ||
    echo "Test failed" >> "$LOG"
cat "$LOG"
if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
